/* hdl/sine_menu_pkg.sv */
package sine_menu_pkg;

    //////////////////////////////////////////////////////////
    // Front-panel buttons
    //////////////////////////////////////////////////////////

    localparam int NUM_BUTTONS = 4;

    // Bit positions inside the button vector
    localparam int BTN_PREV   = 0;
    localparam int BTN_NEXT   = 1;
    localparam int BTN_OKAY   = 2;
    localparam int BTN_CANCEL = 3;

    //////////////////////////////////////////////////////////
    // Menu layout
    //////////////////////////////////////////////////////////

    localparam int CURSOR_W = 4;
    localparam logic [CURSOR_W-1:0] MAX_CURSOR_INDEX = 4'd10;

    // Items that pick one to five drawn periods
    localparam logic [CURSOR_W-1:0] CURSOR_PERIOD1 = 4'd3;
    localparam logic [CURSOR_W-1:0] CURSOR_PERIOD2 = 4'd4;
    localparam logic [CURSOR_W-1:0] CURSOR_PERIOD3 = 4'd5;
    localparam logic [CURSOR_W-1:0] CURSOR_PERIOD4 = 4'd6;
    localparam logic [CURSOR_W-1:0] CURSOR_PERIOD5 = 4'd7;

    // Code 0..4 means 1..5 periods
    localparam int PERIODS_W = 3;

    // Offset-binary samples, one period per phase wrap
    localparam int SAMPLE_W           = 8;
    localparam int SAMPLES_PER_PERIOD = 16;
    localparam int PHASE_W            = 4;

endpackage

/* hdl/button_debounce.sv */
`timescale 1ns/1ps

module button_debounce import sine_menu_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  logic [NUM_BUTTONS-1:0] buttons,
    output logic [NUM_BUTTONS-1:0] press_pulse
);

    // Counter must be able to hold DEBOUNCE_CYCLES itself
    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_DONE = CNT_W'(DEBOUNCE_CYCLES);

    logic [NUM_BUTTONS-1:0] sync_q1;
    logic [NUM_BUTTONS-1:0] sync_q2;
    logic [NUM_BUTTONS-1:0] stable;
    logic [CNT_W-1:0]       hold_cnt [NUM_BUTTONS];

    ////////////////////////////////////////////////////////////
    // Two-flop synchronizer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= buttons;
            sync_q2 <= sync_q1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stability counters and press strobes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stable      <= '0;
            press_pulse <= '0;
            for (int i = 0; i < NUM_BUTTONS; i++) begin
                hold_cnt[i] <= '0;
            end
        end else if (!en) begin
            stable      <= '0;
            press_pulse <= '0;
            for (int i = 0; i < NUM_BUTTONS; i++) begin
                hold_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_BUTTONS; i++) begin
                // Strobe lasts a single cycle
                press_pulse[i] <= 1'b0;
                if (sync_q2[i] != stable[i]) begin
                    if (hold_cnt[i] == CNT_DONE) begin
                        // New level accepted, pulse only on press
                        stable[i]      <= sync_q2[i];
                        press_pulse[i] <= sync_q2[i];
                        hold_cnt[i]    <= '0;
                    end else begin
                        hold_cnt[i] <= hold_cnt[i] + 1'b1;
                    end
                end else begin
                    // Bounce back to the old level restarts the count
                    hold_cnt[i] <= '0;
                end
            end
        end
    end

endmodule

/* hdl/menu_navigator.sv */
`timescale 1ns/1ps

module menu_navigator import sine_menu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  logic [NUM_BUTTONS-1:0] press_pulse,
    output logic [CURSOR_W-1:0]    cursor_index,
    output logic [PERIODS_W-1:0]   active_periods
);

    logic                 period_item;
    logic [PERIODS_W-1:0] period_code;

    ////////////////////////////////////////////////////////////
    // Period item decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        period_item = 1'b1;
        period_code = '0;
        case (cursor_index)
            CURSOR_PERIOD1: period_code = PERIODS_W'(0);
            CURSOR_PERIOD2: period_code = PERIODS_W'(1);
            CURSOR_PERIOD3: period_code = PERIODS_W'(2);
            CURSOR_PERIOD4: period_code = PERIODS_W'(3);
            CURSOR_PERIOD5: period_code = PERIODS_W'(4);
            default: begin
                // Okay here selects nothing
                period_item = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Cursor and selection registers
    ////////////////////////////////////////////////////////////

    // Priority is Previous, Next, Okay
    // Cancel bit is not looked at
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cursor_index   <= '0;
            active_periods <= '0;
        end else if (!en) begin
            cursor_index   <= '0;
            active_periods <= '0;
        end else if (press_pulse[BTN_PREV]) begin
            // Wrap from first item to last
            if (cursor_index == '0) begin
                cursor_index <= MAX_CURSOR_INDEX;
            end else begin
                cursor_index <= cursor_index - 1'b1;
            end
        end else if (press_pulse[BTN_NEXT]) begin
            // Wrap from last item to first
            if (cursor_index >= MAX_CURSOR_INDEX) begin
                cursor_index <= '0;
            end else begin
                cursor_index <= cursor_index + 1'b1;
            end
        end else if (press_pulse[BTN_OKAY] && period_item) begin
            active_periods <= period_code;
        end
    end

endmodule

/* hdl/sine_quarter_lut.sv */
`timescale 1ns/1ps

module sine_quarter_lut import sine_menu_pkg::*; (
    input  logic [PHASE_W-1:0]  phase,
    output logic [SAMPLE_W-1:0] sample_value
);

    localparam int HALF_PERIOD    = SAMPLES_PER_PERIOD / 2;
    localparam int QUARTER_PERIOD = SAMPLES_PER_PERIOD / 4;
    localparam logic [SAMPLE_W-1:0] MIDSCALE = SAMPLE_W'(1 << (SAMPLE_W - 1));

    logic                negative;
    logic [PHASE_W-2:0]  half_phase;
    logic [PHASE_W-2:0]  quarter_idx;
    logic [SAMPLE_W-2:0] magnitude;

    // Second half of the period is the negated first half
    assign negative   = phase[PHASE_W-1];
    assign half_phase = phase[PHASE_W-2:0];

    // Falling part of each half mirrors the rising part
    assign quarter_idx = (int'(half_phase) > QUARTER_PERIOD) ?
                         (PHASE_W-1)'(HALF_PERIOD - int'(half_phase)) :
                         half_phase;

    ////////////////////////////////////////////////////////////
    // Quarter-wave magnitudes, 127 * sin(k * pi / 8)
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (quarter_idx)
            3'd0:    magnitude = 7'd0;
            3'd1:    magnitude = 7'd49;
            3'd2:    magnitude = 7'd90;
            3'd3:    magnitude = 7'd117;
            3'd4:    magnitude = 7'd127;
            default: magnitude = 7'd0;
        endcase
    end

    // Offset binary around mid-scale
    assign sample_value = negative ? (MIDSCALE - {1'b0, magnitude}) :
                                     (MIDSCALE + {1'b0, magnitude});

endmodule

/* hdl/wave_streamer.sv */
`timescale 1ns/1ps

module wave_streamer import sine_menu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    input  logic [PERIODS_W-1:0] active_periods,
    output logic [PHASE_W-1:0]   phase,
    input  logic [SAMPLE_W-1:0]  sample_value,
    output logic [SAMPLE_W-1:0]  sample_data,
    output logic                 sample_valid,
    input  logic                 sample_ready,
    output logic                 sample_last
);

    localparam logic [PHASE_W-1:0] LAST_PHASE = PHASE_W'(SAMPLES_PER_PERIOD - 1);

    // Position of the next sample to load
    logic [PHASE_W-1:0]   phase_cnt;
    logic [PERIODS_W-1:0] period_cnt;
    // Period code held for the frame in progress
    logic [PERIODS_W-1:0] frame_periods;

    logic                 frame_start;
    logic                 end_of_period;
    logic                 end_of_frame;
    logic                 load;

    ////////////////////////////////////////////////////////////
    // Frame position decode
    ////////////////////////////////////////////////////////////

    assign phase       = phase_cnt;
    assign frame_start = (phase_cnt == '0) && (period_cnt == '0);

    // Frame length follows the code latched at its first sample
    assign end_of_period = (phase_cnt == LAST_PHASE);
    assign end_of_frame  = end_of_period && (period_cnt == frame_periods);

    // Output register empty or being drained this cycle
    assign load = !sample_valid || sample_ready;

    ////////////////////////////////////////////////////////////
    // Sequencer and stream control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_cnt     <= '0;
            period_cnt    <= '0;
            frame_periods <= '0;
            sample_valid  <= 1'b0;
            sample_last   <= 1'b0;
        end else if (!en) begin
            phase_cnt     <= '0;
            period_cnt    <= '0;
            frame_periods <= '0;
            sample_valid  <= 1'b0;
            sample_last   <= 1'b0;
        end else if (load) begin
            sample_valid <= 1'b1;
            sample_last  <= end_of_frame;
            if (frame_start) begin
                frame_periods <= active_periods;
            end
            if (end_of_period) begin
                phase_cnt <= '0;
                // Next frame starts right after the last sample
                period_cnt <= end_of_frame ? '0 : period_cnt + 1'b1;
            end else begin
                phase_cnt <= phase_cnt + 1'b1;
            end
        end
    end

    // Sample payload held while stalled
    always_ff @(posedge clk) begin
        if (!en) begin
            sample_data <= '0;
        end else if (load) begin
            sample_data <= sample_value;
        end
    end

endmodule

/* hdl/sine_menu_top.sv */
`timescale 1ns/1ps

module sine_menu_top import sine_menu_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  logic [NUM_BUTTONS-1:0] buttons,
    output logic [CURSOR_W-1:0]    cursor_index,
    output logic [PERIODS_W-1:0]   active_periods,
    output logic [SAMPLE_W-1:0]    sample_data,
    output logic                   sample_valid,
    input  logic                   sample_ready,
    output logic                   sample_last
);

    logic [NUM_BUTTONS-1:0] press_pulse;
    logic [PHASE_W-1:0]     phase;
    logic [SAMPLE_W-1:0]    sample_value;

    ////////////////////////////////////////////////////////////
    // Button front end and menu
    ////////////////////////////////////////////////////////////

    button_debounce #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_debounce (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .buttons     (buttons),
        .press_pulse (press_pulse)
    );

    // Selection also steers the streamer
    menu_navigator u_navigator (
        .clk            (clk),
        .rst_n          (rst_n),
        .en             (en),
        .press_pulse    (press_pulse),
        .cursor_index   (cursor_index),
        .active_periods (active_periods)
    );

    ////////////////////////////////////////////////////////////
    // Sample path
    ////////////////////////////////////////////////////////////

    wave_streamer u_streamer (
        .clk            (clk),
        .rst_n          (rst_n),
        .en             (en),
        .active_periods (active_periods),
        .phase          (phase),
        .sample_value   (sample_value),
        .sample_data    (sample_data),
        .sample_valid   (sample_valid),
        .sample_ready   (sample_ready),
        .sample_last    (sample_last)
    );

    sine_quarter_lut u_lut (
        .phase        (phase),
        .sample_value (sample_value)
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    // Free-running clock, low at time zero
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

/* verification/tb_sine_menu.sv */
`timescale 1ns/1ps

module tb_sine_menu import sine_menu_pkg::*; ();

    localparam int DEBOUNCE_CYCLES = 4;
    localparam int TIMEOUT_CYCLES  = 20000;

    logic                   clk;
    logic                   rst_n;
    logic                   en;
    logic [NUM_BUTTONS-1:0] buttons;
    logic [CURSOR_W-1:0]    cursor_index;
    logic [PERIODS_W-1:0]   active_periods;
    logic [SAMPLE_W-1:0]    sample_data;
    logic                   sample_valid;
    logic                   sample_ready;
    logic                   sample_last;

    // One full period, offset binary
    logic [SAMPLE_W-1:0] ref_table [SAMPLES_PER_PERIOD] = '{
        8'd128, 8'd177, 8'd218, 8'd245, 8'd255, 8'd245, 8'd218, 8'd177,
        8'd128, 8'd79,  8'd38,  8'd11,  8'd1,   8'd11,  8'd38,  8'd79
    };

    // Expected menu state
    logic [CURSOR_W-1:0]  cursor_model;
    logic [PERIODS_W-1:0] periods_model;

    // Beats of the last received frame
    logic [SAMPLE_W-1:0] frame_data [$];
    logic                frame_last [$];

    int error_count = 0;
    int press_count = 0;
    int frame_count = 0;
    int cycle_count = 0;

    tb_clock_gen #(.PERIOD_NS (8.0)) u_clock (.clk (clk));

    sine_menu_top #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .en             (en),
        .buttons        (buttons),
        .cursor_index   (cursor_index),
        .active_periods (active_periods),
        .sample_data    (sample_data),
        .sample_valid   (sample_valid),
        .sample_ready   (sample_ready),
        .sample_last    (sample_last)
    );

    // Hard stop well past the summed test length
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic check_menu();
        if (cursor_index !== cursor_model) begin
            report_mismatch("cursor_index", 32'(cursor_model), 32'(cursor_index));
        end
        if (active_periods !== periods_model) begin
            report_mismatch("active_periods", 32'(periods_model), 32'(active_periods));
        end
    endtask

    // Menu rules for one accepted press
    function automatic void apply_press(input int btn);
        case (btn)
            BTN_PREV: begin
                if (cursor_model == '0) begin
                    cursor_model = MAX_CURSOR_INDEX;
                end else begin
                    cursor_model = cursor_model - 1'b1;
                end
            end
            BTN_NEXT: begin
                if (cursor_model == MAX_CURSOR_INDEX) begin
                    cursor_model = '0;
                end else begin
                    cursor_model = cursor_model + 1'b1;
                end
            end
            BTN_OKAY: begin
                if (cursor_model >= CURSOR_PERIOD1 && cursor_model <= CURSOR_PERIOD5) begin
                    periods_model = PERIODS_W'(cursor_model - CURSOR_PERIOD1);
                end
            end
            default: begin
                // Cancel does nothing
            end
        endcase
    endfunction

    // Bouncy press, fixed-latency check, hold, clean release
    task automatic press_button(input int btn, input int hold_cycles);
        int bounces;
        int len;
        bounces = 1 + int'($urandom % 3);
        for (int i = 0; i < bounces; i++) begin
            // Each burst stays below the debounce count
            len = 1 + int'($urandom % (DEBOUNCE_CYCLES - 1));
            @(posedge clk);
            buttons[btn] <= 1'b1;
            repeat (len) @(posedge clk);
            buttons[btn] <= 1'b0;
            len = 1 + int'($urandom % (DEBOUNCE_CYCLES - 1));
            repeat (len - 1) @(posedge clk);
        end
        @(posedge clk);
        buttons[btn] <= 1'b1;
        press_count++;
        // One cycle before the expected step
        repeat (DEBOUNCE_CYCLES + 3) @(posedge clk);
        @(negedge clk);
        check_menu();
        apply_press(btn);
        @(posedge clk);
        @(negedge clk);
        check_menu();
        repeat (hold_cycles) @(posedge clk);
        buttons[btn] <= 1'b0;
        // Held level and release give no further step
        repeat (DEBOUNCE_CYCLES + 6) @(posedge clk);
        @(negedge clk);
        check_menu();
    endtask

    task automatic move_cursor_to(input int target);
        while (int'(cursor_model) != target) begin
            press_button(BTN_NEXT, 2);
        end
    endtask

    // Collect beats up to and including the next last
    task automatic receive_frame(input bit random_ready);
        bit                  stalled;
        bit                  done;
        logic [SAMPLE_W-1:0] held_data;
        logic                held_last;
        stalled   = 1'b0;
        done      = 1'b0;
        held_data = '0;
        held_last = 1'b0;
        frame_data.delete();
        frame_last.delete();
        while (!done) begin
            @(posedge clk);
            if (random_ready) begin
                sample_ready <= 1'($urandom);
            end else begin
                sample_ready <= 1'b1;
            end
            @(negedge clk);
            // Stalled beat must come back unchanged
            if (stalled) begin
                if (sample_valid !== 1'b1) begin
                    report_mismatch("sample_valid", 32'd1, 32'(sample_valid));
                end
                if (sample_data !== held_data) begin
                    report_mismatch("sample_data", 32'(held_data), 32'(sample_data));
                end
                if (sample_last !== held_last) begin
                    report_mismatch("sample_last", 32'(held_last), 32'(sample_last));
                end
            end
            stalled   = sample_valid && !sample_ready;
            held_data = sample_data;
            held_last = sample_last;
            // Transfer happens on the coming edge
            if (sample_valid && sample_ready) begin
                frame_data.push_back(sample_data);
                frame_last.push_back(sample_last);
                done = sample_last;
            end
        end
        frame_count++;
    endtask

    task automatic check_frame(input int code);
        int expected_len;
        expected_len = SAMPLES_PER_PERIOD * (code + 1);
        if (frame_data.size() != expected_len) begin
            report_mismatch("frame length", expected_len, frame_data.size());
        end
        for (int i = 0; i < frame_data.size(); i++) begin
            if (frame_data[i] !== ref_table[i % SAMPLES_PER_PERIOD]) begin
                report_mismatch("sample_data", 32'(ref_table[i % SAMPLES_PER_PERIOD]),
                                32'(frame_data[i]));
            end
            if (frame_last[i] !== (i == frame_data.size() - 1)) begin
                report_mismatch("sample_last", 32'(i == frame_data.size() - 1),
                                32'(frame_last[i]));
            end
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////

    initial begin
        int old_code;
        void'($urandom(32'he83d_4bb8));
        rst_n         = 1'b0;
        en            = 1'b0;
        buttons       = '0;
        sample_ready  = 1'b0;
        cursor_model  = '0;
        periods_model = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Idle after reset, en still low
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (sample_valid !== 1'b0) begin
            report_mismatch("sample_valid", 32'd0, 32'(sample_valid));
        end
        if (sample_last !== 1'b0) begin
            report_mismatch("sample_last", 32'd0, 32'(sample_last));
        end
        check_menu();
        @(posedge clk);
        en <= 1'b1;
        repeat (2) @(posedge clk);

        // Navigation with wrap in both directions
        press_button(BTN_NEXT, 2);
        repeat (10) press_button(BTN_NEXT, 2);
        if (cursor_index !== '0) begin
            report_mismatch("cursor_index", 32'd0, 32'(cursor_index));
        end
        press_button(BTN_PREV, 2);
        if (cursor_index !== MAX_CURSOR_INDEX) begin
            report_mismatch("cursor_index", 32'(MAX_CURSOR_INDEX), 32'(cursor_index));
        end
        press_button(BTN_NEXT, 100);

        // Period selection and ignored presses
        for (int n = 1; n <= 5; n++) begin
            move_cursor_to(int'(CURSOR_PERIOD1) + n - 1);
            press_button(BTN_OKAY, 2);
            if (active_periods !== PERIODS_W'(n - 1)) begin
                report_mismatch("active_periods", n - 1, 32'(active_periods));
            end
        end
        move_cursor_to(9);
        press_button(BTN_OKAY, 2);
        move_cursor_to(0);
        press_button(BTN_OKAY, 2);
        press_button(BTN_CANCEL, 2);

        // Full-rate stream after aligning to a frame start
        receive_frame(1'b0);
        receive_frame(1'b0);
        check_frame(int'(periods_model));

        // Random back-pressure
        receive_frame(1'b1);
        receive_frame(1'b1);
        check_frame(int'(periods_model));

        // Selection change lands in mid-frame
        old_code = int'(periods_model);
        move_cursor_to(int'(CURSOR_PERIOD1));
        receive_frame(1'b0);
        fork
            receive_frame(1'b0);
            press_button(BTN_OKAY, 2);
        join
        check_frame(old_code);
        receive_frame(1'b0);
        check_frame(int'(periods_model));

        // Nonzero selection so the clear is visible
        move_cursor_to(int'(CURSOR_PERIOD2));
        press_button(BTN_OKAY, 2);

        // en low clears everything on the next edge
        @(posedge clk);
        en <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        cursor_model  = '0;
        periods_model = '0;
        if (sample_valid !== 1'b0) begin
            report_mismatch("sample_valid", 32'd0, 32'(sample_valid));
        end
        if (sample_last !== 1'b0) begin
            report_mismatch("sample_last", 32'd0, 32'(sample_last));
        end
        if (sample_data !== '0) begin
            report_mismatch("sample_data", 32'd0, 32'(sample_data));
        end
        check_menu();
        @(posedge clk);
        en <= 1'b1;
        // Restart from phase 0
        receive_frame(1'b0);
        check_frame(0);

        $display("summary: %0d errors, %0d presses, %0d frames",
                 error_count, press_count, frame_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
hdl/sine_menu_pkg.sv
hdl/button_debounce.sv
hdl/menu_navigator.sv
hdl/sine_quarter_lut.sv
hdl/wave_streamer.sv
hdl/sine_menu_top.sv
verification/tb_clock_gen.sv
verification/tb_sine_menu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module tb_sine_menu \
    -f flist.f \
    -o sim_sine_menu \
    && ./obj_dir/sim_sine_menu | tee /dev/stderr | grep -q "^Test OK$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
